/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing -j 0
TOP      ?= radar_mono_tb
FILELIST ?= radar_mono.f
OBJ_DIR  ?= obj_dir

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* bench/chirp_testdata.txt */
# w <addr hex> <data hex> : register write, applied in order
# d <word hex>            : expected DAC word, I then Q for each sample
w 10 ffff
w 41 0008
w 42 0005
w 43 000c
w 44 0c00
w 45 0800
d 1ff5
d 0191
d 1e20
d 0ac7
d 157c
d 17b5
d 0191
d 1ff5
d 284b
d 157c
d 21e0
d 3539
d 0191
d 200b
d 1ff5
d 3e6f

/* bench/radar_mono_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the radar core
// Data file load, frame monitor,
// compare tasks, reset, frame and loop tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module radar_mono_tb;

   import dsp_pkg::*;
   import radar_pkg::*;

   logic       clk_i;
   logic       rst_n_i;
   reg_addr_t  saddr_i;
   logic       s_strobe_i;
   logic [31:0] sdata_i;
   iq_sample_t rx_adc_i;
   dac_word_t  tx_a_o;
   dac_word_t  tx_b_o;
   logic       txsync_a_o;
   logic       txsync_b_o;
   iq_sample_t rx_echo_o;
   logic       rx_strobe_o;
   logic       busy_o;

   // Register writes and expected DAC words from the data file
   reg_addr_t   file_addr[$];
   logic [31:0] file_data[$];
   dac_word_t   exp_dac[$];
   bit          file_ok;
   int          tx_len;
   int          rx_delay;
   int          rx_len;

   // Frame monitor state
   logic       exp_side;
   logic       q_due;
   iq_sample_t adc_prev;
   int         cycle;
   int         sync_count;
   int         rx_count;
   int         word_count;
   int         first_rx_cycle;
   int         last_sync_cycle;

   int dac_errors;
   int echo_errors;
   int count_errors;
   int other_errors;

   radar_mono dut_i (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .saddr_i(saddr_i), .s_strobe_i(s_strobe_i),
      .sdata_i(sdata_i), .rx_adc_i(rx_adc_i), .tx_a_o(tx_a_o), .tx_b_o(tx_b_o),
      .txsync_a_o(txsync_a_o), .txsync_b_o(txsync_b_o), .rx_echo_o(rx_echo_o),
      .rx_strobe_o(rx_strobe_o), .busy_o(busy_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // Halved sum of two samples by arithmetic shift
   function automatic sample_t pair_average(input sample_t a, input sample_t b);
      int sum;
      sum = int'(a) + int'(b);
      return sample_t'(sum >>> 1);
   endfunction

   task automatic check_dac(input dac_word_t got, input dac_word_t exp, input string what);
      if (got !== exp) begin
         $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
         dac_errors++;
      end
   endtask

   task automatic check_echo(input iq_sample_t got, input iq_sample_t exp, input string what);
      if (got !== exp) begin
         $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
         echo_errors++;
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
         count_errors++;
      end
   endtask

   // Lines are '#' comments, "w addr data" writes, "d word" DAC words
   task automatic load_testdata();
      int          fd;
      int          n;
      string       line;
      string       rest;
      logic [31:0] a;
      logic [31:0] b;
      file_ok = 1'b0;
      fd = $fopen("bench/chirp_testdata.txt", "r");
      if (fd == 0) begin
         $display("Could not open the chirp test data file");
         other_errors++;
         return;
      end
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n > 2 && line.getc(0) != "#") begin
            rest = line.substr(2, line.len() - 1);
            if (line.getc(0) == "w") begin
               n = $sscanf(rest, "%h %h", a, b);
               file_addr.push_back(a[6:0]);
               file_data.push_back(b);
               // Frame timing needed by the count checks
               if (a[6:0] == REG_TX_LEN) tx_len = int'(b[15:0]);
               if (a[6:0] == REG_RX_DELAY) rx_delay = int'(b[15:0]);
               if (a[6:0] == REG_RX_LEN) rx_len = int'(b[15:0]);
            end else if (line.getc(0) == "d") begin
               n = $sscanf(rest, "%h", b);
               exp_dac.push_back(b[DAC_W-1:0]);
            end
         end
      end
      $fclose(fd);
      file_ok = (exp_dac.size() != 0);
      if (!file_ok) begin
         $display("The chirp test data file holds no expected DAC words");
         other_errors++;
      end
   endtask

   task automatic clear_frame_stats();
      q_due           = 1'b0;
      sync_count      = 0;
      rx_count        = 0;
      word_count      = 0;
      first_rx_cycle  = -1;
      last_sync_cycle = -1;
   endtask

   // Sample outputs 1 ns after the edge, then drive inputs
   task automatic step_cycle();
      dac_word_t  act_word;
      dac_word_t  idle_word;
      dac_word_t  exp;
      logic       act_sync;
      logic       idle_sync;
      iq_sample_t exp_echo;
      @(posedge clk_i);
      #1;
      cycle++;
      act_word  = exp_side ? tx_b_o : tx_a_o;
      act_sync  = exp_side ? txsync_b_o : txsync_a_o;
      idle_word = exp_side ? tx_a_o : tx_b_o;
      idle_sync = exp_side ? txsync_a_o : txsync_b_o;
      check_dac(idle_word, '0, "idle side word");
      check_count(int'(idle_sync), 0, "idle side sync");
      // I word with sync, Q word right after, zero otherwise
      if (act_sync || q_due) begin
         exp = (exp_dac.size() == 0) ? '0 : exp_dac[word_count % exp_dac.size()];
         check_dac(act_word, exp, "chirp word");
         word_count++;
         if (act_sync) begin
            sync_count++;
            last_sync_cycle = cycle;
         end
         q_due = act_sync;
      end else begin
         check_dac(act_word, '0, "DAC word between samples");
      end
      // Pair made of the two ADC values captured at the last two edges
      if (rx_strobe_o) begin
         rx_count++;
         if (first_rx_cycle < 0) first_rx_cycle = cycle;
         exp_echo.i = pair_average(adc_prev.i, rx_adc_i.i);
         exp_echo.q = pair_average(adc_prev.q, rx_adc_i.q);
         check_echo(rx_echo_o, exp_echo, "echo average");
      end
      adc_prev   = rx_adc_i;
      rx_adc_i   = $urandom();
      s_strobe_i = 1'b0;
   endtask

   // Strobe stays up for exactly one cycle
   task automatic write_reg(input reg_addr_t addr, input logic [31:0] data);
      step_cycle();
      saddr_i    = addr;
      sdata_i    = data;
      s_strobe_i = 1'b1;
   endtask

   task automatic check_quiet();
      check_dac(tx_a_o, '0, "side A word in quiet period");
      check_dac(tx_b_o, '0, "side B word in quiet period");
      check_echo(rx_echo_o, '0, "echo in quiet period");
      check_count(int'({busy_o, txsync_a_o, txsync_b_o, rx_strobe_o}), 0,
                  "control outputs in quiet period");
   endtask

   task automatic wait_busy_high();
      int n;
      n = 0;
      while (!busy_o && n < 20) begin
         step_cycle();
         n++;
      end
      if (!busy_o) begin
         $display("Timeout: busy_o did not rise after the start write");
         other_errors++;
      end
   endtask

   task automatic wait_for_syncs(input int target);
      int n;
      n = 0;
      while (sync_count < target && n < 500) begin
         step_cycle();
         n++;
      end
      if (sync_count < target) begin
         $display("Timeout: the second chirp frame never started");
         other_errors++;
      end
   endtask

   task automatic run_until_idle();
      int n;
      n = 0;
      while (busy_o && n < 1000) begin
         step_cycle();
         n++;
      end
      if (busy_o) begin
         $display("Timeout: busy_o did not fall at the end of the run");
         other_errors++;
      end
   endtask

   initial begin
      rst_n_i    = 1'b0;
      saddr_i    = '0;
      sdata_i    = '0;
      s_strobe_i = 1'b0;
      rx_adc_i   = '0;
      adc_prev   = '0;
      exp_side   = 1'b0;
      cycle      = 0;
      tx_len     = 0;
      rx_delay   = 0;
      rx_len     = 0;
      dac_errors   = 0;
      echo_errors  = 0;
      count_errors = 0;
      other_errors = 0;
      void'($urandom(32'h1ac6_7dd2));
      clear_frame_stats();
      load_testdata();

      // Reset held, then a few idle cycles before any write
      repeat (16) begin
         step_cycle();
         check_quiet();
      end
      rst_n_i = 1'b1;
      repeat (8) begin
         step_cycle();
         check_quiet();
      end

      if (file_ok) begin
         foreach (file_addr[k]) write_reg(file_addr[k], file_data[k]);
         repeat (4) begin
            step_cycle();
            check_quiet();
         end

         // Single frame on side A
         clear_frame_stats();
         exp_side = 1'b0;
         write_reg(REG_CTRL, 32'h1);
         wait_busy_high();
         run_until_idle();
         repeat (8) step_cycle();
         check_count(word_count, exp_dac.size(), "side A chirp words");
         check_count(sync_count, tx_len, "side A sync pulses");
         check_count(rx_count, rx_len / 2, "echo strobes in one frame");
         if (first_rx_cycle - last_sync_cycle < rx_delay) begin
            $display("FAIL %0t: first echo %0d cycles after last sync, expected at least %0d",
                     $time, first_rx_cycle - last_sync_cycle, rx_delay);
            count_errors++;
         end

         // Loop on side B, loop dropped during the second frame
         clear_frame_stats();
         exp_side = 1'b1;
         write_reg(REG_CTRL, 32'h7);
         wait_busy_high();
         wait_for_syncs(tx_len + 1);
         write_reg(REG_CTRL, 32'h4);
         run_until_idle();
         repeat (8) step_cycle();
         check_count(word_count, 2 * exp_dac.size(), "side B chirp words in two frames");
         check_count(sync_count, 2 * tx_len, "side B sync pulses in two frames");
         check_count(rx_count, rx_len, "echo strobes in two frames");
      end

      $display("Errors: dac %0d, echo %0d, count %0d, other %0d",
               dac_errors, echo_errors, count_errors, other_errors);
      if (dac_errors + echo_errors + count_errors + other_errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* radar_mono.f */
source/dsp_pkg.sv
source/radar_pkg.sv
source/radar_regs.sv
source/radar_timer.sv
source/chirp_gen.sv
source/dac_interface.sv
source/echo_capture.sv
source/radar_mono.sv
bench/radar_mono_tb.sv

/* source/chirp_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Linear FM chirp generator
// Ramped phase accumulator and
// quarter-wave sine/cosine lookup
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module chirp_gen (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  radar_pkg::radar_cfg_t  cfg_i,
   input  logic                   frame_start_i,
   input  logic                   tx_strobe_i,
   output dsp_pkg::iq_sample_t    tx_iq_o,
   output logic                   tx_valid_o
);

   import dsp_pkg::*;
   import radar_pkg::*;

   logic [PHASE_W-1:0]   phase_r;
   logic [PHASE_W-1:0]   incr_r;
   logic [PHASE_W-1:0]   cur_phase_c;
   logic [PHASE_W-1:0]   cur_incr_c;
   // Quadrant and table index of the sample in flight
   logic [1:0]           quad_r;
   logic [QTR_IDX_W-1:0] idx_r;
   logic                 stage1_vld_r;

   // Quadrant picks mirroring and sign
   function automatic sample_t qtr_lookup(input logic [1:0] quad,
                                          input logic [QTR_IDX_W-1:0] idx);
      logic [QTR_IDX_W-1:0] addr;
      int                   mag;
      addr = quad[0] ? ~idx : idx;
      mag  = (CHIRP_AMP * QTR_SIN_Q15[addr]) >>> 15;
      return quad[1] ? -sample_t'(mag) : sample_t'(mag);
   endfunction

   // New frame restarts from phase zero and f_start
   assign cur_phase_c = frame_start_i ? '0 : phase_r;
   assign cur_incr_c  = frame_start_i ? cfg_i.f_start : incr_r;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         phase_r      <= '0;
         incr_r       <= '0;
         stage1_vld_r <= 1'b0;
         tx_valid_o   <= 1'b0;
         tx_iq_o      <= '0;
      end else begin
         stage1_vld_r <= tx_strobe_i;
         tx_valid_o   <= stage1_vld_r;
         if (tx_strobe_i) begin
            // Sample taken first, then phase and frequency step
            phase_r <= cur_phase_c + cur_incr_c;
            incr_r  <= cur_incr_c + cfg_i.f_step;
         end
         // Cosine is sine one quadrant ahead
         if (stage1_vld_r) begin
            tx_iq_o.i <= qtr_lookup(quad_r + 2'd1, idx_r);
            tx_iq_o.q <= qtr_lookup(quad_r, idx_r);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (tx_strobe_i) begin
         quad_r <= cur_phase_c[PHASE_W-1 -: 2];
         idx_r  <= cur_phase_c[PHASE_W-3 -: QTR_IDX_W];
      end
   end

endmodule

/* source/dac_interface.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DAC interleaver
// I then Q on one word, sync on I
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module dac_interface (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  dsp_pkg::iq_sample_t  tx_iq_i,
   input  logic                 tx_valid_i,
   output dsp_pkg::dac_word_t   dac_o,
   output logic                 sync_o
);

   import dsp_pkg::*;

   // Q word waiting for its slot
   dac_word_t q_hold_r;
   // Interleave phase, Q still owed
   logic      q_pend_r;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         dac_o    <= '0;
         sync_o   <= 1'b0;
         q_pend_r <= 1'b0;
      end else if (tx_valid_i) begin
         // Low bits kept, chirp amplitude already fits
         dac_o    <= tx_iq_i.i[DAC_W-1:0];
         sync_o   <= 1'b1;
         q_pend_r <= 1'b1;
      end else if (q_pend_r) begin
         dac_o    <= q_hold_r;
         sync_o   <= 1'b0;
         q_pend_r <= 1'b0;
      end else begin
         // Idle between samples
         dac_o    <= '0;
         sync_o   <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (tx_valid_i) begin
         q_hold_r <= tx_iq_i.q[DAC_W-1:0];
      end
   end

endmodule

/* source/dsp_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample formats for the radar datapath
// Sample and DAC word widths, I/Q struct
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package dsp_pkg;

   // One I or Q component
   localparam int SAMPLE_W = 16;
   // DAC converter word
   localparam int DAC_W = 14;

   typedef logic signed [SAMPLE_W-1:0] sample_t;

   // I in the upper half, Q in the lower half
   typedef struct packed {
      sample_t i;
      sample_t q;
   } iq_sample_t;

   typedef logic signed [DAC_W-1:0] dac_word_t;

endpackage

/* source/echo_capture.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Echo capture
// Pairwise average of ADC samples
// inside the receive window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module echo_capture (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 rx_window_i,
   input  dsp_pkg::iq_sample_t  rx_adc_i,
   output dsp_pkg::iq_sample_t  rx_echo_o,
   output logic                 rx_strobe_o
);

   import dsp_pkg::*;

   // Set while the odd sample of a pair is due
   logic       pair_r;
   iq_sample_t even_r;

   // Sum with one guard bit, then halve
   function automatic sample_t avg2(input sample_t a, input sample_t b);
      logic signed [SAMPLE_W:0] sum;
      logic signed [SAMPLE_W:0] half;
      sum  = {a[SAMPLE_W-1], a} + {b[SAMPLE_W-1], b};
      half = sum >>> 1;
      return half[SAMPLE_W-1:0];
   endfunction

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pair_r      <= 1'b0;
         rx_strobe_o <= 1'b0;
         rx_echo_o   <= '0;
      end else begin
         // Outside the window the pairing restarts
         pair_r      <= rx_window_i && !pair_r;
         rx_strobe_o <= rx_window_i && pair_r;
         if (rx_window_i && pair_r) begin
            rx_echo_o.i <= avg2(even_r.i, rx_adc_i.i);
            rx_echo_o.q <= avg2(even_r.q, rx_adc_i.q);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rx_window_i && !pair_r) begin
         even_r <= rx_adc_i;
      end
   end

endmodule

/* source/radar_mono.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Monostatic pulse radar core top level
// Block wiring and side A/B DAC routing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module radar_mono (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  radar_pkg::reg_addr_t  saddr_i,
   input  logic                  s_strobe_i,
   input  logic [31:0]           sdata_i,
   input  dsp_pkg::iq_sample_t   rx_adc_i,
   output dsp_pkg::dac_word_t    tx_a_o,
   output dsp_pkg::dac_word_t    tx_b_o,
   output logic                  txsync_a_o,
   output logic                  txsync_b_o,
   output dsp_pkg::iq_sample_t   rx_echo_o,
   output logic                  rx_strobe_o,
   output logic                  busy_o
);

   import dsp_pkg::*;
   import radar_pkg::*;

   radar_cfg_t cfg;
   logic       start;
   logic       frame_start;
   logic       tx_strobe;
   logic       rx_window;
   iq_sample_t tx_iq;
   logic       tx_valid;
   dac_word_t  tx_dac;
   logic       tx_sync;

   radar_regs regs (.clk_i(clk_i), .rst_n_i(rst_n_i), .saddr_i(saddr_i),
                    .sdata_i(sdata_i), .s_strobe_i(s_strobe_i),
                    .cfg_o(cfg), .start_o(start));

   radar_timer timer (.clk_i(clk_i), .rst_n_i(rst_n_i), .cfg_i(cfg), .start_i(start),
                      .frame_start_o(frame_start), .tx_strobe_o(tx_strobe),
                      .rx_window_o(rx_window), .busy_o(busy_o));

   chirp_gen chirp (.clk_i(clk_i), .rst_n_i(rst_n_i), .cfg_i(cfg),
                    .frame_start_i(frame_start), .tx_strobe_i(tx_strobe),
                    .tx_iq_o(tx_iq), .tx_valid_o(tx_valid));

   dac_interface dac (.clk_i(clk_i), .rst_n_i(rst_n_i), .tx_iq_i(tx_iq),
                      .tx_valid_i(tx_valid), .dac_o(tx_dac), .sync_o(tx_sync));

   echo_capture echo (.clk_i(clk_i), .rst_n_i(rst_n_i), .rx_window_i(rx_window),
                      .rx_adc_i(rx_adc_i), .rx_echo_o(rx_echo_o),
                      .rx_strobe_o(rx_strobe_o));

   // Chirp to side B when tx_side set, idle side held at zero
   assign tx_a_o     = cfg.tx_side ? '0 : tx_dac;
   assign tx_b_o     = cfg.tx_side ? tx_dac : '0;
   assign txsync_a_o = cfg.tx_side ? 1'b0 : tx_sync;
   assign txsync_b_o = cfg.tx_side ? tx_sync : 1'b0;

endmodule

/* source/radar_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Radar control definitions
// Register map, configuration struct,
// frame states and chirp table constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package radar_pkg;

   typedef logic [6:0] reg_addr_t;

   // Register map
   localparam reg_addr_t REG_CTRL     = 7'd64;
   localparam reg_addr_t REG_TX_LEN   = 7'd65;
   localparam reg_addr_t REG_RX_DELAY = 7'd66;
   localparam reg_addr_t REG_RX_LEN   = 7'd67;
   localparam reg_addr_t REG_F_START  = 7'd68;
   localparam reg_addr_t REG_F_STEP   = 7'd69;

   // REG_CTRL bit positions
   localparam int CTRL_GO_BIT   = 0;
   localparam int CTRL_LOOP_BIT = 1;
   localparam int CTRL_SIDE_BIT = 2;

   // Phase accumulator width
   localparam int PHASE_W = 16;

   typedef struct packed {
      logic               loop;
      logic               tx_side;
      logic [15:0]        tx_len;
      logic [15:0]        rx_delay;
      logic [15:0]        rx_len;
      logic [PHASE_W-1:0] f_start;
      logic [PHASE_W-1:0] f_step;
   } radar_cfg_t;

   typedef enum logic [1:0] {
      FR_IDLE,
      FR_TX,
      FR_WAIT,
      FR_RX
   } frame_state_t;

   localparam int QTR_TABLE_DEPTH = 16;
   localparam int QTR_IDX_W       = $clog2(QTR_TABLE_DEPTH);
   // Peak amplitude, fits a 14-bit signed DAC word
   localparam int CHIRP_AMP       = 8191;

   // sin((k + 0.5) * pi / 32) in Q15, half-step offset keeps mirroring exact
   localparam int QTR_SIN_Q15 [QTR_TABLE_DEPTH] = '{
      1608, 4808, 7962, 11039, 14010, 16846, 19520, 22006,
      24279, 26320, 28106, 29622, 30852, 31786, 32413, 32729
   };

endpackage

/* source/radar_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Radar configuration registers
// Strobed write decode and start pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module radar_regs (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  radar_pkg::reg_addr_t   saddr_i,
   input  logic [31:0]            sdata_i,
   input  logic                   s_strobe_i,
   output radar_pkg::radar_cfg_t  cfg_o,
   output logic                   start_o
);

   import radar_pkg::*;

   logic ctrl_wr_c;

   // Write to the control register this cycle
   assign ctrl_wr_c = s_strobe_i && (saddr_i == REG_CTRL);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cfg_o   <= '0;
         start_o <= 1'b0;
      end else begin
         // Go bit is never stored, only pulses
         start_o <= ctrl_wr_c && sdata_i[CTRL_GO_BIT];
         if (s_strobe_i) begin
            case (saddr_i)
               REG_CTRL: begin
                  cfg_o.loop    <= sdata_i[CTRL_LOOP_BIT];
                  cfg_o.tx_side <= sdata_i[CTRL_SIDE_BIT];
               end
               REG_TX_LEN:   cfg_o.tx_len   <= sdata_i[15:0];
               REG_RX_DELAY: cfg_o.rx_delay <= sdata_i[15:0];
               // Receive window kept even so samples pair up
               REG_RX_LEN:   cfg_o.rx_len   <= {sdata_i[15:1], 1'b0};
               REG_F_START:  cfg_o.f_start  <= sdata_i[PHASE_W-1:0];
               REG_F_STEP:   cfg_o.f_step   <= sdata_i[PHASE_W-1:0];
               // Unknown addresses dropped
               default: ;
            endcase
         end
      end
   end

endmodule

/* source/radar_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame sequencer
// Transmit, wait and receive phases,
// half-rate transmit strobe, loop mode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module radar_timer (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  radar_pkg::radar_cfg_t  cfg_i,
   input  logic                   start_i,
   output logic                   frame_start_o,
   output logic                   tx_strobe_o,
   output logic                   rx_window_o,
   output logic                   busy_o
);

   import radar_pkg::*;

   frame_state_t state_r;
   // Cycles left in the current phase, minus one
   logic [16:0]  cnt_r;
   // High on the second cycle of each transmit pair
   logic         half_r;
   logic         last_c;

   assign last_c = (cnt_r == '0);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_r       <= FR_IDLE;
         cnt_r         <= '0;
         half_r        <= 1'b0;
         frame_start_o <= 1'b0;
      end else begin
         frame_start_o <= 1'b0;
         half_r        <= ~half_r;
         cnt_r         <= cnt_r - 17'd1;
         case (state_r)
            FR_IDLE: begin
               // Start while busy never reaches here
               if (start_i) begin
                  state_r       <= FR_TX;
                  cnt_r         <= {cfg_i.tx_len, 1'b0} - 17'd1;
                  half_r        <= 1'b0;
                  frame_start_o <= 1'b1;
               end
            end
            FR_TX: begin
               if (last_c) begin
                  // Zero delay skips straight to listening
                  if (cfg_i.rx_delay != '0) begin
                     state_r <= FR_WAIT;
                     cnt_r   <= {1'b0, cfg_i.rx_delay} - 17'd1;
                  end else begin
                     state_r <= FR_RX;
                     cnt_r   <= {1'b0, cfg_i.rx_len} - 17'd1;
                  end
               end
            end
            FR_WAIT: begin
               if (last_c) begin
                  state_r <= FR_RX;
                  cnt_r   <= {1'b0, cfg_i.rx_len} - 17'd1;
               end
            end
            FR_RX: begin
               // Loop checked only here, run ends after this frame
               if (last_c) begin
                  if (cfg_i.loop) begin
                     state_r       <= FR_TX;
                     cnt_r         <= {cfg_i.tx_len, 1'b0} - 17'd1;
                     half_r        <= 1'b0;
                     frame_start_o <= 1'b1;
                  end else begin
                     state_r <= FR_IDLE;
                  end
               end
            end
            default: state_r <= FR_IDLE;
         endcase
      end
   end

   // First cycle of every pair carries the strobe
   assign tx_strobe_o = (state_r == FR_TX) && !half_r;
   assign rx_window_o = (state_r == FR_RX);
   assign busy_o      = (state_r != FR_IDLE);

endmodule
